//--- rtl/congestion_pkg.sv
package congestion_pkg;

    // router geometry
    localparam int NUM_PORTS = 5;
    localparam int NUM_VCS = 4;
    localparam int PV = NUM_PORTS * NUM_VCS;         // all VCs of the router

    // congestion level widths
    localparam int CONG_W = 2;                       // per port
    localparam int CONG_ALL_W = CONG_W * NUM_PORTS;  // per router
    localparam int PRESEL_W = 4;                     // one bit per quadrant

    // deadlock watchdog
    localparam int DL_MAX_CLK = 16;
    localparam int DL_CNT_W = 4;

    // port j, vc i lives at bit j*NUM_VCS+i
    localparam int PORT_LOCAL = 0;
    localparam int PORT_EAST = 1;                    // x plus
    localparam int PORT_NORTH = 2;                   // y plus
    localparam int PORT_WEST = 3;                    // x minus
    localparam int PORT_SOUTH = 4;                   // y minus

    // quadrant bit positions in the pre-selection
    localparam int Q_XM_YM = 0;
    localparam int Q_XM_YP = 1;
    localparam int Q_XP_YM = 2;
    localparam int Q_XP_YP = 3;

    localparam logic XDIR = 1'b0;
    localparam logic YDIR = 1'b1;

    typedef logic [PV-1:0] vc_all_t;
    typedef logic [CONG_W-1:0] cong_t;               // 0 least, 3 most congested
    typedef logic [CONG_ALL_W-1:0] cong_all_t;
    typedef logic [PRESEL_W-1:0] presel_t;

    typedef enum logic {
        CONG_SRC_NOTGRANT = 1'b0,
        CONG_SRC_AVB_OVC = 1'b1
    } cong_src_e;

endpackage

//--- rtl/count_normalize.sv
`timescale 1ns/1ps

module count_normalize #(
    parameter int IN_W = 12,
    parameter int OUT_W = 2
) (
    input  logic [IN_W-1:0]  bits,
    output logic [OUT_W-1:0] level
);

    localparam int CNT_W = $clog2(IN_W + 1);
    localparam int LEVELS = 2 ** OUT_W;

    logic [CNT_W-1:0] cnt;

    // population count
    always_comb begin
        cnt = '0;
        for (int i = 0; i < IN_W; i++) begin
            cnt = cnt + CNT_W'(bits[i]);
        end
    end

    // level k once the count passes k/LEVELS of the input width;
    // thresholds only grow with k, so the last hit wins
    always_comb begin
        level = '0;
        for (int k = 1; k < LEVELS; k++) begin
            if (int'(cnt) > (IN_W * k) / LEVELS) begin
                level = OUT_W'(k);
            end
        end
    end

endmodule

//--- rtl/ivc_notgrant_congestion.sv
`timescale 1ns/1ps

module ivc_notgrant_congestion (
    input  logic                      clk,
    input  logic                      rst_n,
    input  congestion_pkg::vc_all_t   ivc_request,
    input  congestion_pkg::vc_all_t   ivc_sw_grant,
    output congestion_pkg::cong_all_t congestion
);

    localparam int NUM_W = $clog2(congestion_pkg::PV + 1);

    congestion_pkg::vc_all_t notgrant_q;  // requests left waiting last cycle
    logic [NUM_W-1:0]        notgrant_num;
    congestion_pkg::cong_t   level;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            notgrant_q <= '0;
        end else begin
            notgrant_q <= ivc_request & ~ivc_sw_grant;
        end
    end

    always_comb begin
        notgrant_num = '0;
        for (int i = 0; i < congestion_pkg::PV; i++) begin
            notgrant_num = notgrant_num + NUM_W'(notgrant_q[i]);
        end
    end

    // uneven grading, most of the range is spent on light load
    always_comb begin
        if (int'(notgrant_num) <= congestion_pkg::PV / 10) begin
            level = 2'd0;                 // up to 10 percent
        end else if (int'(notgrant_num) <= congestion_pkg::PV / 5) begin
            level = 2'd1;                 // up to 20 percent
        end else if (int'(notgrant_num) <= congestion_pkg::PV / 2) begin
            level = 2'd2;                 // up to half
        end else begin
            level = 2'd3;
        end
    end

    // same level towards every port
    assign congestion = {congestion_pkg::NUM_PORTS{level}};

endmodule

//--- rtl/avb_ovc_congestion.sv
`timescale 1ns/1ps

module avb_ovc_congestion (
    input  congestion_pkg::vc_all_t   ovc_available,
    output congestion_pkg::cong_all_t congestion
);

    localparam int V = congestion_pkg::NUM_VCS;
    localparam int CW = congestion_pkg::CONG_W;
    localparam int E = congestion_pkg::PORT_EAST;
    localparam int N = congestion_pkg::PORT_NORTH;
    localparam int W = congestion_pkg::PORT_WEST;
    localparam int S = congestion_pkg::PORT_SOUTH;

    logic [V-1:0]   ovc_not_avb [E:S];
    logic [3*V-1:0] cnt_in [E:S];  // neighbour ports only

    for (genvar p = E; p <= S; p++) begin : g_split
        assign ovc_not_avb[p] = ~ovc_available[p*V +: V];
    end

    // each neighbour sees the busy OVCs of the other three
    assign cnt_in[E] = {ovc_not_avb[N], ovc_not_avb[W], ovc_not_avb[S]};
    assign cnt_in[N] = {ovc_not_avb[E], ovc_not_avb[W], ovc_not_avb[S]};
    assign cnt_in[W] = {ovc_not_avb[E], ovc_not_avb[N], ovc_not_avb[S]};
    assign cnt_in[S] = {ovc_not_avb[E], ovc_not_avb[N], ovc_not_avb[W]};

    for (genvar p = E; p <= S; p++) begin : g_port
        count_normalize #(
            .IN_W  (3 * V),
            .OUT_W (CW)
        ) u_norm (
            .bits  (cnt_in[p]),
            .level (congestion[p*CW +: CW])
        );
    end

    // nothing to report towards the local core
    assign congestion[congestion_pkg::PORT_LOCAL*CW +: CW] = '0;

endmodule

//--- rtl/congestion_out_gen.sv
`timescale 1ns/1ps

module congestion_out_gen (
    input  logic                      clk,
    input  logic                      rst_n,
    input  congestion_pkg::cong_src_e cong_src,
    input  congestion_pkg::vc_all_t   ivc_request,
    input  congestion_pkg::vc_all_t   ivc_sw_grant,
    input  congestion_pkg::vc_all_t   ovc_available,
    output congestion_pkg::cong_all_t congestion_out
);

    congestion_pkg::cong_all_t notgrant_cong;  // one cycle behind the inputs
    congestion_pkg::cong_all_t avb_ovc_cong;   // same cycle as the inputs
    congestion_pkg::cong_all_t cong_next;

    ivc_notgrant_congestion u_notgrant (
        .clk          (clk),
        .rst_n        (rst_n),
        .ivc_request  (ivc_request),
        .ivc_sw_grant (ivc_sw_grant),
        .congestion   (notgrant_cong)
    );

    avb_ovc_congestion u_avb_ovc (
        .ovc_available (ovc_available),
        .congestion    (avb_ovc_cong)
    );

    // cong_src is held static while running
    always_comb begin
        if (cong_src == congestion_pkg::CONG_SRC_AVB_OVC) begin
            cong_next = avb_ovc_cong;
        end else begin
            cong_next = notgrant_cong;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            congestion_out <= '0;
        end else begin
            congestion_out <= cong_next;
        end
    end

endmodule

//--- rtl/port_presel.sv
`timescale 1ns/1ps

module port_presel (
    input  logic                      clk,
    input  logic                      rst_n,
    input  congestion_pkg::cong_all_t congestion_in,
    output congestion_pkg::presel_t   port_pre_sel
);

    localparam int CW = congestion_pkg::CONG_W;

    congestion_pkg::cong_t   cong_xp;  // east
    congestion_pkg::cong_t   cong_yp;  // north
    congestion_pkg::cong_t   cong_xm;  // west
    congestion_pkg::cong_t   cong_ym;  // south
    congestion_pkg::presel_t cmp;

    assign cong_xp = congestion_in[congestion_pkg::PORT_EAST*CW +: CW];
    assign cong_yp = congestion_in[congestion_pkg::PORT_NORTH*CW +: CW];
    assign cong_xm = congestion_in[congestion_pkg::PORT_WEST*CW +: CW];
    assign cong_ym = congestion_in[congestion_pkg::PORT_SOUTH*CW +: CW];

    // go along y only when the x neighbour is strictly worse, ties keep x
    assign cmp[congestion_pkg::Q_XP_YP] =
        (cong_xp > cong_yp) ? congestion_pkg::YDIR : congestion_pkg::XDIR;
    assign cmp[congestion_pkg::Q_XM_YP] =
        (cong_xm > cong_yp) ? congestion_pkg::YDIR : congestion_pkg::XDIR;
    assign cmp[congestion_pkg::Q_XP_YM] =
        (cong_xp > cong_ym) ? congestion_pkg::YDIR : congestion_pkg::XDIR;
    assign cmp[congestion_pkg::Q_XM_YM] =
        (cong_xm > cong_ym) ? congestion_pkg::YDIR : congestion_pkg::XDIR;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            port_pre_sel <= '0;
        end else begin
            port_pre_sel <= cmp;
        end
    end

endmodule

//--- rtl/deadlock_detector.sv
`timescale 1ns/1ps

module deadlock_detector (
    input  logic                    clk,
    input  logic                    rst_n,
    input  congestion_pkg::vc_all_t ivc_request,
    input  congestion_pkg::vc_all_t ivc_sw_grant,
    output logic                    deadlock_detect
);

    localparam int P = congestion_pkg::NUM_PORTS;
    localparam int V = congestion_pkg::NUM_VCS;
    localparam int CNT_W = congestion_pkg::DL_CNT_W;

    congestion_pkg::vc_all_t grant_q;
    logic [P-1:0]            clr_gen [V];
    logic [P-1:0]            inc_gen [V];
    logic [V-1:0]            cnt_clr;
    logic [V-1:0]            cnt_inc;
    logic [V-1:0]            at_limit;
    logic [CNT_W-1:0]        cnt_q [V];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_q <= '0;
        end else begin
            grant_q <= ivc_sw_grant;
        end
    end

    for (genvar i = 0; i < V; i++) begin : g_vc
        // gather vc i of every port
        for (genvar j = 0; j < P; j++) begin : g_port
            assign clr_gen[i][j] = grant_q[j*V + i];
            assign inc_gen[i][j] = ivc_request[j*V + i];
        end

        assign cnt_clr[i] = |clr_gen[i];
        assign cnt_inc[i] = |inc_gen[i];

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                cnt_q[i] <= '0;
            end else if (cnt_clr[i]) begin
                cnt_q[i] <= '0;
            end else if (cnt_inc[i]) begin
                cnt_q[i] <= cnt_q[i] + 1'b1;  // wraps past the limit
            end
        end

        assign at_limit[i] = (cnt_q[i] == CNT_W'(congestion_pkg::DL_MAX_CLK - 1));
    end

    assign deadlock_detect = |at_limit;

endmodule

//--- rtl/congestion_unit.sv
`timescale 1ns/1ps

module congestion_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  congestion_pkg::cong_src_e cong_src,
    input  congestion_pkg::vc_all_t   ivc_request,
    input  congestion_pkg::vc_all_t   ivc_sw_grant,
    input  congestion_pkg::vc_all_t   ovc_available,
    input  congestion_pkg::cong_all_t congestion_in,
    output congestion_pkg::cong_all_t congestion_out,
    output congestion_pkg::presel_t   port_pre_sel,
    output logic                      deadlock_detect
);

    // outgoing level sent to the neighbours
    congestion_out_gen u_cong_out (
        .clk            (clk),
        .rst_n          (rst_n),
        .cong_src       (cong_src),
        .ivc_request    (ivc_request),
        .ivc_sw_grant   (ivc_sw_grant),
        .ovc_available  (ovc_available),
        .congestion_out (congestion_out)
    );

    // incoming levels steer the x/y choice
    port_presel u_presel (
        .clk           (clk),
        .rst_n         (rst_n),
        .congestion_in (congestion_in),
        .port_pre_sel  (port_pre_sel)
    );

    deadlock_detector u_deadlock (
        .clk             (clk),
        .rst_n           (rst_n),
        .ivc_request     (ivc_request),
        .ivc_sw_grant    (ivc_sw_grant),
        .deadlock_detect (deadlock_detect)
    );

endmodule

//--- dv/tb_congestion_unit.sv
`timescale 1ns/1ps

module tb_congestion_unit;

    localparam int P = congestion_pkg::NUM_PORTS;
    localparam int V = congestion_pkg::NUM_VCS;
    localparam int PV = congestion_pkg::PV;
    localparam int CW = congestion_pkg::CONG_W;
    localparam int RANDOM_CYCLES = 1000;       // per metric
    localparam int MAX_CYCLES = 3000;          // about 2100 cycles of stimulus in total
    localparam int STALL_PORT = congestion_pkg::PORT_WEST;
    localparam int STALL_VC = 2;

    logic                      clk;
    logic                      rst_n;
    congestion_pkg::cong_src_e cong_src;
    congestion_pkg::vc_all_t   ivc_request;
    congestion_pkg::vc_all_t   ivc_sw_grant;
    congestion_pkg::vc_all_t   ovc_available;
    congestion_pkg::cong_all_t congestion_in;
    congestion_pkg::cong_all_t congestion_out;
    congestion_pkg::presel_t   port_pre_sel;
    logic                      deadlock_detect;

    // reference model state
    congestion_pkg::vc_all_t   ng_q_m;
    congestion_pkg::vc_all_t   grant_q_m;
    congestion_pkg::cong_all_t exp_cong_out;
    congestion_pkg::presel_t   exp_presel;
    logic [3:0]                dl_cnt_m [V];
    logic                      exp_deadlock;

    logic [15:0] lfsr_state;
    int          cycle_count;
    int          mismatch_count;
    int          other_count;
    logic        dl_seen;

    congestion_unit dut0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .cong_src        (cong_src),
        .ivc_request     (ivc_request),
        .ivc_sw_grant    (ivc_sw_grant),
        .ovc_available   (ovc_available),
        .congestion_in   (congestion_in),
        .congestion_out  (congestion_out),
        .port_pre_sel    (port_pre_sel),
        .deadlock_detect (deadlock_detect)
    );

    always #2 clk = ~clk;

    // 16-bit galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val[i] = lfsr_state[0];
        end
    endtask

    // density in quarters, 0 gives all zero and 4 all ones
    task automatic rand_vec(input int density, output congestion_pkg::vc_all_t v);
        logic [15:0] r;
        for (int i = 0; i < PV; i++) begin
            rand_bits(2, r);
            v[i] = (int'(r[1:0]) < density);
        end
    endtask

    function automatic congestion_pkg::cong_t grade_notgrant(input int n);
        if (n <= 2) return 2'd0;
        else if (n <= 4) return 2'd1;
        else if (n <= 10) return 2'd2;
        else return 2'd3;
    endfunction

    function automatic congestion_pkg::cong_t scale_busy(input int n);
        if (n <= 3) return 2'd0;      // quarters of twelve OVCs
        else if (n <= 6) return 2'd1;
        else if (n <= 9) return 2'd2;
        else return 2'd3;
    endfunction

    function automatic congestion_pkg::cong_all_t avb_expect(input congestion_pkg::vc_all_t avb);
        congestion_pkg::cong_all_t r;
        int busy [P];
        int total;
        r = '0;
        for (int p = 0; p < P; p++) begin
            busy[p] = $countones(~avb[p*V +: V]);
        end
        for (int p = congestion_pkg::PORT_EAST; p <= congestion_pkg::PORT_SOUTH; p++) begin
            total = busy[1] + busy[2] + busy[3] + busy[4] - busy[p];  // other three neighbours
            r[p*CW +: CW] = scale_busy(total);
        end
        return r;
    endfunction

    function automatic congestion_pkg::presel_t presel_expect(input congestion_pkg::cong_all_t c);
        congestion_pkg::presel_t r;
        congestion_pkg::cong_t   e;
        congestion_pkg::cong_t   n;
        congestion_pkg::cong_t   w;
        congestion_pkg::cong_t   s;
        e = c[congestion_pkg::PORT_EAST*CW +: CW];
        n = c[congestion_pkg::PORT_NORTH*CW +: CW];
        w = c[congestion_pkg::PORT_WEST*CW +: CW];
        s = c[congestion_pkg::PORT_SOUTH*CW +: CW];
        r[congestion_pkg::Q_XP_YP] = (e > n) ? congestion_pkg::YDIR : congestion_pkg::XDIR;
        r[congestion_pkg::Q_XM_YP] = (w > n) ? congestion_pkg::YDIR : congestion_pkg::XDIR;
        r[congestion_pkg::Q_XP_YM] = (e > s) ? congestion_pkg::YDIR : congestion_pkg::XDIR;
        r[congestion_pkg::Q_XM_YM] = (w > s) ? congestion_pkg::YDIR : congestion_pkg::XDIR;
        return r;
    endfunction

    function automatic logic vc_on_any_port(input congestion_pkg::vc_all_t v, input int vc);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < P; p++) begin
            hit = hit | v[p*V + vc];
        end
        return hit;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ng_q_m <= '0;
            grant_q_m <= '0;
            exp_cong_out <= '0;
            exp_presel <= '0;
            for (int i = 0; i < V; i++) begin
                dl_cnt_m[i] <= '0;
            end
        end else begin
            ng_q_m <= ivc_request & ~ivc_sw_grant;
            if (cong_src == congestion_pkg::CONG_SRC_AVB_OVC) begin
                exp_cong_out <= avb_expect(ovc_available);
            end else begin
                exp_cong_out <= {P{grade_notgrant($countones(ng_q_m))}};
            end
            exp_presel <= presel_expect(congestion_in);
            grant_q_m <= ivc_sw_grant;
            for (int i = 0; i < V; i++) begin
                if (vc_on_any_port(grant_q_m, i)) begin
                    dl_cnt_m[i] <= '0;
                end else if (vc_on_any_port(ivc_request, i)) begin
                    dl_cnt_m[i] <= dl_cnt_m[i] + 4'd1;  // wraps at 16
                end
            end
        end
    end

    assign exp_deadlock = (dl_cnt_m[0] == 4'd15) || (dl_cnt_m[1] == 4'd15) ||
                          (dl_cnt_m[2] == 4'd15) || (dl_cnt_m[3] == 4'd15);

    // outputs settle after the rising edge, so compare on the falling one
    assert property (@(negedge clk) congestion_out === exp_cong_out)
    else begin
        mismatch_count++;
        $display("mismatch at %0t: congestion_out dut=%h exp=%h",
                 $time, congestion_out, exp_cong_out);
    end

    assert property (@(negedge clk) port_pre_sel === exp_presel)
    else begin
        mismatch_count++;
        $display("mismatch at %0t: port_pre_sel dut=%h exp=%h", $time, port_pre_sel, exp_presel);
    end

    assert property (@(negedge clk) deadlock_detect === exp_deadlock)
    else begin
        mismatch_count++;
        $display("mismatch at %0t: deadlock_detect dut=%b exp=%b",
                 $time, deadlock_detect, exp_deadlock);
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic run_random(input congestion_pkg::cong_src_e src, input int cycles);
        congestion_pkg::vc_all_t req;
        congestion_pkg::vc_all_t gnt;
        congestion_pkg::vc_all_t avb;
        logic [15:0]             cin;
        for (int c = 0; c < cycles; c++) begin
            rand_vec((c / 20) % 5, req);       // sweeps sparse to dense
            rand_vec((c / 100) % 5, gnt);      // slower so every pairing shows up
            rand_vec((c / 30) % 5, avb);
            rand_bits(CW * P, cin);
            @(negedge clk);
            cong_src = src;
            ivc_request = req;
            ivc_sw_grant = gnt;
            ovc_available = avb;
            congestion_in = cin[CW*P-1:0];
        end
    endtask

    // one VC requested and never granted until the watchdog fires
    task automatic run_stall();
        @(negedge clk);
        ivc_request = '0;
        ivc_sw_grant = '1;                     // clear every counter first
        repeat (2) @(negedge clk);
        ivc_sw_grant = '0;
        ivc_request[STALL_PORT*V + STALL_VC] = 1'b1;
        repeat (20) begin
            @(negedge clk);
            if (deadlock_detect) dl_seen = 1'b1;
        end
        ivc_sw_grant[STALL_PORT*V + STALL_VC] = 1'b1;
        @(negedge clk);
        ivc_sw_grant = '0;
        repeat (20) @(negedge clk);            // long enough to reach the limit again
        ivc_request = '0;
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        cong_src = congestion_pkg::CONG_SRC_NOTGRANT;
        ivc_request = '0;
        ivc_sw_grant = '0;
        ovc_available = '1;
        congestion_in = '0;
        lfsr_state = 16'd56;
        cycle_count = 0;
        mismatch_count = 0;
        other_count = 0;
        dl_seen = 1'b0;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (10) @(negedge clk);            // idle, outputs stay at zero

        run_random(congestion_pkg::CONG_SRC_NOTGRANT, RANDOM_CYCLES);
        run_random(congestion_pkg::CONG_SRC_AVB_OVC, RANDOM_CYCLES);
        run_stall();
        repeat (10) @(negedge clk);

        if (!dl_seen) begin
            other_count++;
            $display("deadlock_detect never rose while a VC was stalled");
        end
        $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
        if (mismatch_count + other_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
rtl/congestion_pkg.sv
rtl/count_normalize.sv
rtl/ivc_notgrant_congestion.sv
rtl/avb_ovc_congestion.sv
rtl/congestion_out_gen.sv
rtl/port_presel.sv
rtl/deadlock_detector.sv
rtl/congestion_unit.sv
dv/tb_congestion_unit.sv

//--- Makefile
# Verilator build for the congestion unit testbench

VERILATOR ?= verilator
TOP       ?= tb_congestion_unit
RTL_TOP   ?= congestion_unit
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= RESULT: PASS

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the run passes only when the pass line shows up in the output
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
